//--- hw/isa_pkg.sv
// ISA widths, opcode constant, R/I instruction views and instruction word union
package isa_pkg;

    localparam int XLEN         = 32;   // Data and PC width
    localparam int ARCH_REG_NUM = 32;   // x0..x31
    localparam int REG_IDX_W    = 5;

    // ------------------------------
    // Opcodes
    // ------------------------------
    localparam logic [6:0] OPC_OP = 7'b0110011;   // Reg-reg ALU ops, R-type

    // R-type view, two sources
    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_type_t;

    // I-type view, rs2 slot is immediate
    typedef struct packed {
        logic [11:0]          imm;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_type_t;

    // One word, decoded by opcode
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } inst_u;

endpackage

//--- hw/ooo_pkg.sv
// Out-of-order core widths and the dispatch, completion and retire records
package ooo_pkg;

    localparam int TAG_W     = 6;   // Up to 64 physical regs
    localparam int ROB_IDX_W = 5;   // Up to 32 ROB entries

    // ------------------------------
    // Dispatch record
    // ------------------------------
    typedef struct packed {
        logic                         valid;
        logic [ROB_IDX_W-1:0]         rob_idx;
        logic [TAG_W-1:0]             src1_tag;
        logic [TAG_W-1:0]             src2_tag;
        logic                         src2_used;   // Low for I-type
        logic                         has_dest;    // rd != x0
        logic [TAG_W-1:0]             new_tag;
        logic [TAG_W-1:0]             old_tag;     // Freed on retire
        logic [isa_pkg::XLEN-1:0]     pc;
    } dispatch_t;

    // Completion bus, no data
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
    } complete_t;

    // ------------------------------
    // Retire record
    // ------------------------------
    typedef struct packed {
        logic                         valid;
        logic [isa_pkg::XLEN-1:0]     pc;
        logic [isa_pkg::REG_IDX_W-1:0] rd;         // Arch dest
        logic [TAG_W-1:0]             new_tag;     // Into arch map
        logic [TAG_W-1:0]             old_tag;     // Back to free list
        logic                         has_dest;
    } retire_t;

endpackage

//--- hw/map_table.sv
`timescale 1ns/1ns
// Map table: speculative and architectural rename maps with flush restore
module map_table (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            exception_i,
    input  logic [isa_pkg::REG_IDX_W-1:0]   rs1_i,
    input  logic [isa_pkg::REG_IDX_W-1:0]   rs2_i,
    input  logic [isa_pkg::REG_IDX_W-1:0]   rd_i,
    input  logic                            alloc_i,      // Already has_dest qualified
    input  logic [ooo_pkg::TAG_W-1:0]       new_tag_i,
    input  ooo_pkg::retire_t                rt_i,
    output logic [ooo_pkg::TAG_W-1:0]       src1_tag_o,
    output logic [ooo_pkg::TAG_W-1:0]       src2_tag_o,
    output logic [ooo_pkg::TAG_W-1:0]       old_tag_o
);
    import isa_pkg::*;
    import ooo_pkg::*;

    logic [TAG_W-1:0] spec_map [ARCH_REG_NUM];   // Front-end view
    logic [TAG_W-1:0] arch_map [ARCH_REG_NUM];   // Committed view
    logic [TAG_W-1:0] arch_nxt [ARCH_REG_NUM];   // Arch map after this edge

    // ------------------------------
    // Lookups, combinational
    // ------------------------------
    assign src1_tag_o = spec_map[rs1_i];
    assign src2_tag_o = spec_map[rs2_i];
    assign old_tag_o  = spec_map[rd_i];   // Previous mapping of dest

    // Retire writes arch map
    always_comb begin
        arch_nxt = arch_map;
        if (rt_i.valid && rt_i.has_dest) begin
            arch_nxt[rt_i.rd] = rt_i.new_tag;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < ARCH_REG_NUM; i++) begin
                spec_map[i] <= TAG_W'(i);   // Identity
                arch_map[i] <= TAG_W'(i);
            end
        end else begin
            arch_map <= arch_nxt;
            // Flush sees a retire at the same edge
            if (exception_i) begin
                spec_map <= arch_nxt;
            end else if (alloc_i) begin
                spec_map[rd_i] <= new_tag_i;
            end
        end
    end

    // x0 stays mapped to tag 0
    a_no_x0_alloc: assert property (@(posedge clk_i) disable iff (rst_i)
        alloc_i |-> rd_i != '0);

endmodule

//--- hw/free_list.sv
`timescale 1ns/1ns
// Free list: circular queue of physical tags, speculative and committed heads
module free_list #(
    parameter int PHY_REG_NUM = 48
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        exception_i,
    input  logic                        alloc_i,      // Pop at speculative head
    input  ooo_pkg::retire_t            rt_i,
    output logic [ooo_pkg::TAG_W-1:0]   head_tag_o,
    output logic                        empty_o
);
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int FL_NUM = PHY_REG_NUM - ARCH_REG_NUM;   // Non-identity tags
    localparam int PTR_W  = $clog2(FL_NUM);
    localparam int CNT_W  = $clog2(FL_NUM + 1);

    logic [TAG_W-1:0] fl_mem [FL_NUM];
    logic [PTR_W-1:0] spec_head;
    logic [PTR_W-1:0] cmt_head;   // Also the tail
    logic [CNT_W-1:0] spec_cnt;   // Tags free from spec head
    logic             push;

    // Wrap for non power-of-two depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FL_NUM - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push       = rt_i.valid && rt_i.has_dest;
    assign head_tag_o = fl_mem[spec_head];
    assign empty_o    = (spec_cnt == '0);

    // ------------------------------
    // Queue update
    // ------------------------------
    // Committed region always holds FL_NUM tags, so a retire pops the
    // committed head and pushes at the tail in the slot it just freed
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < FL_NUM; i++) begin
                fl_mem[i] <= TAG_W'(ARCH_REG_NUM + i);   // 32 up, ascending
            end
            spec_head <= '0;
            cmt_head  <= '0;
            spec_cnt  <= CNT_W'(FL_NUM);
        end else begin
            if (push) begin
                fl_mem[cmt_head] <= rt_i.old_tag;
                cmt_head         <= ptr_inc(cmt_head);
            end
            if (exception_i) begin
                spec_head <= push ? ptr_inc(cmt_head) : cmt_head;   // Rewind
                spec_cnt  <= CNT_W'(FL_NUM);
            end else begin
                if (alloc_i) begin
                    spec_head <= ptr_inc(spec_head);
                end
                spec_cnt <= spec_cnt + CNT_W'(push) - CNT_W'(alloc_i);
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        alloc_i |-> !empty_o);

    // A retired writer always had a tag in flight
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push && !alloc_i && !exception_i |-> spec_cnt < CNT_W'(FL_NUM));

endmodule

//--- hw/reorder_buffer.sv
`timescale 1ns/1ns
// Reorder buffer: in-order entries, completion marking, registered retire, flush
module reorder_buffer #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            exception_i,
    input  logic                            alloc_i,      // Plain dispatch accept
    input  logic [isa_pkg::XLEN-1:0]        pc_i,
    input  logic [isa_pkg::REG_IDX_W-1:0]   rd_i,
    input  logic                            has_dest_i,
    input  logic [ooo_pkg::TAG_W-1:0]       new_tag_i,
    input  logic [ooo_pkg::TAG_W-1:0]       old_tag_i,
    input  ooo_pkg::complete_t              cmp_i,
    output logic [ooo_pkg::ROB_IDX_W-1:0]   tail_idx_o,
    output logic                            full_o,
    output ooo_pkg::retire_t                rt_o
);
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // Payload kept per entry
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic                 has_dest;
        logic [TAG_W-1:0]     new_tag;
        logic [TAG_W-1:0]     old_tag;
    } rob_entry_t;

    rob_entry_t           rob_mem [ROB_DEPTH];
    rob_entry_t           head_ent;
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] done;
    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [PTR_W-1:0]     cmp_ptr;
    logic                 rt_fire;   // Head done this cycle

    assign cmp_ptr    = cmp_i.rob_idx[PTR_W-1:0];
    assign head_ent   = rob_mem[head];
    assign rt_fire    = busy[head] && done[head];
    assign full_o     = (count == CNT_W'(ROB_DEPTH));
    assign tail_idx_o = ROB_IDX_W'(tail);

    // ------------------------------
    // Entry payload
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rob_mem[tail] <= '{pc: pc_i, rd: rd_i, has_dest: has_dest_i,
                               new_tag: new_tag_i, old_tag: old_tag_i};
        end
    end

    // ------------------------------
    // Pointers and status bits
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin   // Flush empties the ROB
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_i) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;   // Power of two wrap
            end
            if (cmp_i.valid) begin
                done[cmp_ptr] <= 1'b1;
            end
            if (rt_fire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_i) - CNT_W'(rt_fire);
        end
    end

    // Registered retire, one per cycle
    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            rt_o.valid <= 1'b0;
        end else begin
            rt_o.valid <= rt_fire;
        end
        rt_o.pc       <= head_ent.pc;
        rt_o.rd       <= head_ent.rd;
        rt_o.new_tag  <= head_ent.new_tag;
        rt_o.old_tag  <= head_ent.old_tag;
        rt_o.has_dest <= head_ent.has_dest;
    end

    // Completion bus may only name a live, pending entry
    a_cmp_live: assert property (@(posedge clk_i) disable iff (rst_i || exception_i)
        cmp_i.valid |-> busy[cmp_ptr] && !done[cmp_ptr]);

endmodule

//--- hw/dispatch_ctrl.sv
`timescale 1ns/1ns
// Dispatch control: operand decode, ready/accept decision, registered dispatch record
module dispatch_ctrl (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            exception_i,
    input  logic                            dp_valid_i,
    input  logic [isa_pkg::XLEN-1:0]        dp_pc_i,
    input  isa_pkg::inst_u                  dp_inst_i,
    output logic                            dp_ready_o,
    input  logic                            fl_empty_i,
    input  logic                            rob_full_i,
    input  logic [ooo_pkg::TAG_W-1:0]       head_tag_i,   // Free list head
    input  logic [ooo_pkg::TAG_W-1:0]       src1_tag_i,
    input  logic [ooo_pkg::TAG_W-1:0]       src2_tag_i,
    input  logic [ooo_pkg::TAG_W-1:0]       old_tag_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0]   rob_idx_i,    // ROB tail
    output logic [isa_pkg::REG_IDX_W-1:0]   rs1_o,
    output logic [isa_pkg::REG_IDX_W-1:0]   rs2_o,
    output logic [isa_pkg::REG_IDX_W-1:0]   rd_o,
    output logic                            has_dest_o,
    output logic                            alloc_o,      // Rename alloc, writers only
    output logic                            accept_o,     // Plain accept, to ROB
    output ooo_pkg::dispatch_t              dp_out_o
);
    import isa_pkg::*;
    import ooo_pkg::*;

    logic is_r_type;

    // ------------------------------
    // Decode
    // ------------------------------
    assign is_r_type = (dp_inst_i.r_type.opcode == OPC_OP);

    // rs1 and rd sit in the same slots in both views
    assign rs1_o = dp_inst_i.i_type.rs1;
    assign rd_o  = dp_inst_i.i_type.rd;
    assign rs2_o = is_r_type ? dp_inst_i.r_type.rs2 : '0;   // Imm slot for I-type

    assign has_dest_o = (rd_o != '0);

    // ------------------------------
    // Ready and accept
    // ------------------------------
    // x0 writers need no tag, so an empty free list only stalls real writers
    assign dp_ready_o = !exception_i && !rob_full_i && !(fl_empty_i && has_dest_o);
    assign accept_o   = dp_valid_i && dp_ready_o;
    assign alloc_o    = accept_o && has_dest_o;

    // Record out one cycle after accept
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dp_out_o.valid <= 1'b0;
        end else begin
            dp_out_o.valid <= accept_o;
        end
        if (accept_o) begin
            dp_out_o.rob_idx   <= rob_idx_i;
            dp_out_o.src1_tag  <= src1_tag_i;
            dp_out_o.src2_tag  <= src2_tag_i;
            dp_out_o.src2_used <= is_r_type;
            dp_out_o.has_dest  <= has_dest_o;
            dp_out_o.new_tag   <= has_dest_o ? head_tag_i : '0;
            dp_out_o.old_tag   <= old_tag_i;
            dp_out_o.pc        <= dp_pc_i;
        end
    end

    // A free tag is never the live mapping it replaces
    a_fresh_tag: assert property (@(posedge clk_i) disable iff (rst_i)
        alloc_o |-> head_tag_i != old_tag_i);

endmodule

//--- hw/pipeline_top.sv
`timescale 1ns/1ns
// Rename and retire core top: map table, free list, ROB and dispatch control
module pipeline_top #(
    parameter int PHY_REG_NUM = 48,   // 16 free tags
    parameter int ROB_DEPTH   = 32
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        dp_valid_i,
    input  logic [isa_pkg::XLEN-1:0]    dp_pc_i,
    input  isa_pkg::inst_u              dp_inst_i,
    output logic                        dp_ready_o,
    input  logic                        exception_i,   // One-cycle flush
    input  ooo_pkg::complete_t          cmp_i,
    output ooo_pkg::dispatch_t          dp_out_o,
    output ooo_pkg::retire_t            rt_o
);
    import isa_pkg::*;
    import ooo_pkg::*;

    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    logic                 has_dest;
    logic                 alloc;        // Writers only
    logic                 accept;       // Every accepted inst
    logic [TAG_W-1:0]     head_tag;
    logic                 fl_empty;
    logic [TAG_W-1:0]     src1_tag;
    logic [TAG_W-1:0]     src2_tag;
    logic [TAG_W-1:0]     old_tag;
    logic [ROB_IDX_W-1:0] rob_tail;
    logic                 rob_full;

    // ------------------------------
    // Dispatch
    // ------------------------------
    dispatch_ctrl u_dispatch_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .dp_valid_i  (dp_valid_i),
        .dp_pc_i     (dp_pc_i),
        .dp_inst_i   (dp_inst_i),
        .dp_ready_o  (dp_ready_o),
        .fl_empty_i  (fl_empty),
        .rob_full_i  (rob_full),
        .head_tag_i  (head_tag),
        .src1_tag_i  (src1_tag),
        .src2_tag_i  (src2_tag),
        .old_tag_i   (old_tag),
        .rob_idx_i   (rob_tail),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .has_dest_o  (has_dest),
        .alloc_o     (alloc),
        .accept_o    (accept),
        .dp_out_o    (dp_out_o)
    );

    // ------------------------------
    // Rename state
    // ------------------------------
    map_table u_map_table (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .rd_i        (rd),
        .alloc_i     (alloc),
        .new_tag_i   (head_tag),
        .rt_i        (rt_o),
        .src1_tag_o  (src1_tag),
        .src2_tag_o  (src2_tag),
        .old_tag_o   (old_tag)
    );

    free_list #(
        .PHY_REG_NUM (PHY_REG_NUM)
    ) u_free_list (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .alloc_i     (alloc),
        .rt_i        (rt_o),
        .head_tag_o  (head_tag),
        .empty_o     (fl_empty)
    );

    // ------------------------------
    // Reorder buffer
    // ------------------------------
    reorder_buffer #(
        .ROB_DEPTH   (ROB_DEPTH)
    ) u_reorder_buffer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .alloc_i     (accept),
        .pc_i        (dp_pc_i),
        .rd_i        (rd),
        .has_dest_i  (has_dest),
        .new_tag_i   (head_tag),
        .old_tag_i   (old_tag),
        .cmp_i       (cmp_i),
        .tail_idx_o  (rob_tail),
        .full_o      (rob_full),
        .rt_o        (rt_o)
    );

endmodule

//--- verif/tb_tests.svh
// Directed tests: reset rename, dependent chain, retire order, back-pressure, recycling, flush

task automatic test_reset_rename();
    check_val("dp_out_o.valid", dp_out_o.valid, 1'b0);
    check_val("rt_o.valid", rt_o.valid, 1'b0);
    send_inst(32'h0000_1000, 1'b1, 5'd5, 5'd3, 5'd7);
    // Identity maps, first free tag right above the arch regs
    check_val("dp_out_o.src1_tag", dp_out_o.src1_tag, 3);
    check_val("dp_out_o.src2_tag", dp_out_o.src2_tag, 7);
    check_val("dp_out_o.new_tag", dp_out_o.new_tag, 32);
    check_val("dp_out_o.old_tag", dp_out_o.old_tag, 5);
    check_val("dp_out_o.rob_idx", dp_out_o.rob_idx, 0);
endtask

task automatic test_dep_chain();
    logic [REG_IDX_W-1:0] prev;
    logic [REG_IDX_W-1:0] rd;
    prev = 5'd5;   // Written by the first test
    for (int k = 0; k < 6; k++) begin
        rd = pick_reg();
        send_inst(32'h0000_2000 + 4 * k, (k % 2) == 0, rd, prev, pick_reg());   // R, I, R...
        prev = rd;
    end
    wait_cycles(1);
    check_val("dp_out_o.valid", dp_out_o.valid, 1'b0);   // One cycle only
endtask

task automatic test_retire_order();
    logic [XLEN-1:0] pcs [$];
    int              n;
    int              base;
    n    = rob_q.size();
    base = rob_head;
    foreach (rob_q[k]) begin
        pcs.push_back(rob_q[k].pc);
    end
    for (int k = n - 1; k > 0; k--) begin
        complete_idx((base + k) % ROB_DEPTH);
        check_val("rt_o.valid", rt_o.valid, 1'b0);   // Head still pending
    end
    complete_idx(base);
    for (int k = 0; k < n; k++) begin
        wait_cycles(1);
        check_val("rt_o.valid", rt_o.valid, 1'b1);
        check_val("rt_o.pc", rt_o.pc, pcs[k]);
    end
    wait_cycles(1);
    check_val("rt_o.valid", rt_o.valid, 1'b0);
endtask

task automatic test_back_pressure();
    int n;
    for (int k = 0; k < PHY_REG_NUM - ARCH_REG_NUM; k++) begin
        send_inst(32'h0000_3000 + 4 * k, 1'b0, pick_reg(), pick_reg(), 5'd0);
    end
    probe_ready(5'd9, 1'b0);   // Free list empty
    probe_ready(5'd0, 1'b1);   // x0 writer needs no tag
    n = ROB_DEPTH - rob_q.size();
    for (int k = 0; k < n; k++) begin
        send_inst(32'h0000_4000 + 4 * k, 1'b0, 5'd0, pick_reg(), 5'd0);
    end
    probe_ready(5'd9, 1'b0);
    probe_ready(5'd0, 1'b0);   // ROB full
endtask

task automatic test_tag_recycle();
    int base;
    int n;
    base = rob_head;
    for (int k = 0; k < ROB_DEPTH; k++) begin
        complete_idx((base + k) % ROB_DEPTH);
    end
    n = 0;
    while (rob_q.size() > 0 && n < WAIT_MAX) begin
        wait_cycles(1);
        n++;
    end
    if (rob_q.size() > 0) begin
        err_cnt++;
        $display("Error: %0d instructions did not retire in time", rob_q.size());
    end
    // New tags now come from returned old tags, retire order
    for (int k = 0; k < 4; k++) begin
        send_inst(32'h0000_5000 + 4 * k, 1'b1, pick_reg(), pick_reg(), pick_reg());
    end
endtask

task automatic test_flush();
    logic [REG_IDX_W-1:0] r1;
    logic [REG_IDX_W-1:0] r2;
    logic [TAG_W-1:0]     head_tag;
    r1 = pick_reg();
    r2 = pick_reg();
    send_inst(32'h0000_6000, 1'b0, r1, r2, 5'd0);
    send_inst(32'h0000_6004, 1'b1, r2, r1, r1);
    complete_idx(rob_head);   // Head done, its retire lands on the flush edge
    raise_exception();
    check_val("rt_o.valid", rt_o.valid, 1'b0);
    head_tag = free_q[0];   // Committed head
    send_inst(32'h0000_6008, 1'b1, pick_reg(), r1, r2);
    check_val("dp_out_o.src1_tag", dp_out_o.src1_tag, arch_map[r1]);
    check_val("dp_out_o.src2_tag", dp_out_o.src2_tag, arch_map[r2]);
    check_val("dp_out_o.new_tag", dp_out_o.new_tag, head_tag);
    wait_cycles(6);   // Any stray retire is caught by the monitor
endtask

//--- verif/tb_pipeline_top.sv
`timescale 1ns/1ns
// Testbench top: clock, reset, DUT, rename reference model, drive helpers, watchdog, report
module tb_pipeline_top;
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int PHY_REG_NUM = 48;            // Mirrors DUT defaults
    localparam int ROB_DEPTH   = 32;
    localparam int CLK_PERIOD  = 8;
    localparam int WAIT_MAX    = 50;            // Handshake wait limit, cycles
    localparam int RUN_CYCLES  = 3 + 4 + 10 + 20 + 45 + 45 + 15;   // Reset plus each test
    localparam int MARGIN      = 100;
    localparam logic [6:0] OPC_IMM = 7'b0010011;   // Any non-OP opcode decodes as I-type

    logic            clk = 1'b0;
    logic            rst_i;
    logic            dp_valid_i;
    logic [XLEN-1:0] dp_pc_i;
    inst_u           dp_inst_i;
    logic            dp_ready_o;
    logic            exception_i;
    complete_t       cmp_i;
    dispatch_t       dp_out_o;
    retire_t         rt_o;

    // ------------------------------
    // Reference model
    // ------------------------------
    logic [TAG_W-1:0] spec_map [ARCH_REG_NUM];
    logic [TAG_W-1:0] arch_map [ARCH_REG_NUM];
    logic [TAG_W-1:0] free_q [$];       // Order seen from speculative head
    logic [TAG_W-1:0] inflight_q [$];   // Allocated, not retired, oldest first
    retire_t          rob_q [$];        // Expected retire records in program order
    int               rob_head;
    int               rob_tail;
    int               err_cnt = 0;
    int               chk_cnt = 0;
    int               test_errs = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipeline_top u_pipeline_top (
        .clk_i       (clk),
        .rst_i       (rst_i),
        .dp_valid_i  (dp_valid_i),
        .dp_pc_i     (dp_pc_i),
        .dp_inst_i   (dp_inst_i),
        .dp_ready_o  (dp_ready_o),
        .exception_i (exception_i),
        .cmp_i       (cmp_i),
        .dp_out_o    (dp_out_o),
        .rt_o        (rt_o)
    );

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
        chk_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic report_test(input string name);
        if (err_cnt == test_errs) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, err_cnt - test_errs);
        end
        test_errs = err_cnt;
    endtask

    function automatic logic [REG_IDX_W-1:0] pick_reg();
        return REG_IDX_W'(1 + $urandom % 31);   // x1..x31
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Drive one instruction, wait for ready, check the record a cycle later
    task automatic send_inst(input logic [XLEN-1:0] pc, input logic is_r,
                             input logic [REG_IDX_W-1:0] rd, rs1, rs2);
        dispatch_t want;
        retire_t   rec;
        int        n;
        want           = '0;
        want.valid     = 1'b1;
        want.rob_idx   = ROB_IDX_W'(rob_tail);
        want.src1_tag  = spec_map[rs1];
        want.src2_tag  = spec_map[rs2];
        want.src2_used = is_r;
        want.has_dest  = (rd != '0);
        want.new_tag   = (want.has_dest && free_q.size() > 0) ? free_q[0] : '0;
        want.old_tag   = spec_map[rd];
        want.pc        = pc;
        dp_valid_i = 1'b1;
        dp_pc_i    = pc;
        dp_inst_i  = is_r ? {7'h00, rs2, rs1, 3'h0, rd, OPC_OP}
                          : {12'h004, rs1, 3'h0, rd, OPC_IMM};
        #1;
        n = 0;
        while (!dp_ready_o && n < WAIT_MAX) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!dp_ready_o) begin
            err_cnt++;
            $display("Error: dispatch of pc 0x%0h never became ready", pc);
            dp_valid_i = 1'b0;
            return;
        end
        @(posedge clk);   // Accept edge
        if (want.has_dest) begin
            spec_map[rd] = want.new_tag;
            void'(free_q.pop_front());
            inflight_q.push_back(want.new_tag);
        end
        rec          = '0;
        rec.valid    = 1'b1;
        rec.pc       = pc;
        rec.rd       = rd;
        rec.new_tag  = want.new_tag;
        rec.old_tag  = want.old_tag;
        rec.has_dest = want.has_dest;
        rob_q.push_back(rec);
        rob_tail = (rob_tail + 1) % ROB_DEPTH;
        #1;
        dp_valid_i = 1'b0;
        check_val("dp_out_o.valid", dp_out_o.valid, 1'b1);
        check_val("dp_out_o.rob_idx", dp_out_o.rob_idx, want.rob_idx);
        check_val("dp_out_o.src1_tag", dp_out_o.src1_tag, want.src1_tag);
        if (is_r) begin
            check_val("dp_out_o.src2_tag", dp_out_o.src2_tag, want.src2_tag);
        end
        check_val("dp_out_o.src2_used", dp_out_o.src2_used, want.src2_used);
        check_val("dp_out_o.has_dest", dp_out_o.has_dest, want.has_dest);
        check_val("dp_out_o.new_tag", dp_out_o.new_tag, want.new_tag);
        check_val("dp_out_o.old_tag", dp_out_o.old_tag, want.old_tag);
        check_val("dp_out_o.pc", dp_out_o.pc, want.pc);
    endtask

    task automatic complete_idx(input int idx);
        cmp_i.valid   = 1'b1;
        cmp_i.rob_idx = ROB_IDX_W'(idx);
        @(posedge clk);
        #1;
        cmp_i.valid = 1'b0;
    endtask

    // I-type probe with valid low, ready only
    task automatic probe_ready(input logic [REG_IDX_W-1:0] rd, input logic want_rdy);
        dp_valid_i = 1'b0;
        dp_inst_i  = {12'h004, 5'd1, 3'h0, rd, OPC_IMM};
        #1;
        check_val("dp_ready_o", dp_ready_o, want_rdy);
        @(posedge clk);
        #1;
    endtask

    task automatic raise_exception();
        exception_i = 1'b1;
        #1;
        check_val("dp_ready_o", dp_ready_o, 1'b0);   // Blocked during flush
        @(posedge clk);
        rob_q.delete();
        free_q = {inflight_q, free_q};   // Spec head back to committed head
        inflight_q.delete();
        spec_map = arch_map;
        rob_head = 0;
        rob_tail = 0;
        #1;
        exception_i = 1'b0;
    endtask

    // Retire side of the model, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_i && rt_o.valid) begin
            if (rob_q.size() == 0) begin
                err_cnt++;
                $display("Error: retire at %0t with no instruction in flight", $time);
            end else begin
                check_val("rt_o.pc", rt_o.pc, rob_q[0].pc);
                check_val("rt_o.has_dest", rt_o.has_dest, rob_q[0].has_dest);
                if (rob_q[0].has_dest) begin
                    check_val("rt_o.rd", rt_o.rd, rob_q[0].rd);
                    check_val("rt_o.new_tag", rt_o.new_tag, rob_q[0].new_tag);
                    check_val("rt_o.old_tag", rt_o.old_tag, rob_q[0].old_tag);
                    arch_map[rob_q[0].rd] = rob_q[0].new_tag;
                    free_q.push_back(rob_q[0].old_tag);
                    void'(inflight_q.pop_front());
                end
                void'(rob_q.pop_front());
                rob_head = (rob_head + 1) % ROB_DEPTH;
            end
        end
    end

    `include "tb_tests.svh"

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'haf1d_2428));
        rst_i       = 1'b1;
        dp_valid_i  = 1'b0;
        dp_pc_i     = '0;
        dp_inst_i   = '0;
        exception_i = 1'b0;
        cmp_i       = '0;
        rob_head    = 0;
        rob_tail    = 0;
        for (int i = 0; i < ARCH_REG_NUM; i++) begin
            spec_map[i] = TAG_W'(i);   // Identity after reset
            arch_map[i] = TAG_W'(i);
        end
        for (int t = ARCH_REG_NUM; t < PHY_REG_NUM; t++) begin
            free_q.push_back(TAG_W'(t));
        end
        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;
        test_reset_rename();
        report_test("reset_rename");
        test_dep_chain();
        report_test("dep_chain");
        test_retire_order();
        report_test("retire_order");
        test_back_pressure();
        report_test("back_pressure");
        test_tag_recycle();
        report_test("tag_recycle");
        test_flush();
        report_test("flush");
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + MARGIN));
        $display("Error: watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- list.f
+incdir+verif
hw/isa_pkg.sv
hw/ooo_pkg.sv
hw/map_table.sv
hw/free_list.sv
hw/reorder_buffer.sv
hw/dispatch_ctrl.sv
hw/pipeline_top.sv
verif/tb_pipeline_top.sv
